// ==== build.f ====
+incdir+design
design/alu_op_pkg.sv
design/alu_commit_pkg.sv
design/alu_dispatch.sv
design/alu_int_unit.sv
design/alu_muldiv_unit.sv
design/alu_rsp_arb.sv
design/alu_unit.sv
dv/alu_unit_sva.sv
dv/alu_unit_tb.sv

// ==== Bender.yml ====
package:
  name: alu_unit

sources:
  - include_dirs:
      - design
    files:
      - design/alu_op_pkg.sv
      - design/alu_commit_pkg.sv
      - design/alu_dispatch.sv
      - design/alu_int_unit.sv
      - design/alu_muldiv_unit.sv
      - design/alu_rsp_arb.sv
      - design/alu_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/alu_unit_sva.sv
      - dv/alu_unit_tb.sv

// ==== dv/alu_unit_tb.sv ====
// Testbench for the integer execute cluster
// Directed tests checked against a reference model, commits matched by uuid
`timescale 1ns/10ps
`include "alu_defines.svh"

module alu_unit_tb;
    import alu_op_pkg::*;
    import alu_commit_pkg::*;

    localparam int NL = `ALU_NUM_LANES;
    localparam int N_ARITH = 30;
    localparam int N_BRANCH = 24;
    localparam int N_MULDIV = 21;
    localparam int N_MIXED = 48;
    localparam int N_LATENCY = 6;
    localparam int N_TOTAL = N_ARITH + N_BRANCH + N_MULDIV + N_MIXED + N_LATENCY;
    localparam longint WATCHDOG_NS = (N_TOTAL * 40 + 16) * 10;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      disp_valid;
    exec_req_t disp_req;
    logic      disp_ready;
    logic      commit_valid;
    commit_t   commit_data;
    logic      commit_ready;
    logic      branch_valid;
    branch_t   branch_data;

    logic [31:0] rng = 32'h1ea869d4;
    logic [7:0]  next_uuid = 8'd0;
    logic        rand_ready = 1'b0;
    commit_t     exp_q[$];
    branch_t     br_q[$];

    alu_unit alu_unit_inst (.*);

    bind alu_unit alu_unit_sva sva_inst (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("ERR %0d ns %s expected %h actual %h", $time, name, exp, act);
        abort_run();
    endtask

    task automatic report_problem(string what);
        $display("%0d ns %s", $time, what);
        abort_run();
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_commit(commit_t exp, commit_t act);
        if (act.uuid !== exp.uuid) report_mismatch("commit_data.uuid", exp.uuid, act.uuid);
        if (act.wid !== exp.wid) report_mismatch("commit_data.wid", exp.wid, act.wid);
        if (act.tmask !== exp.tmask) report_mismatch("commit_data.tmask", exp.tmask, act.tmask);
        if (act.pc !== exp.pc) report_mismatch("commit_data.pc", exp.pc, act.pc);
        if (act.rd !== exp.rd) report_mismatch("commit_data.rd", exp.rd, act.rd);
        if (act.wb !== exp.wb) report_mismatch("commit_data.wb", exp.wb, act.wb);
        for (int i = 0; i < NL; i++) begin
            if (act.data[i] !== exp.data[i]) begin
                report_mismatch($sformatf("commit_data.data[%0d]", i), exp.data[i], act.data[i]);
            end
        end
    endtask

    task automatic check_branch(branch_t exp, branch_t act);
        if (act.wid !== exp.wid) report_mismatch("branch_data.wid", exp.wid, act.wid);
        if (act.taken !== exp.taken) report_mismatch("branch_data.taken", exp.taken, act.taken);
        if (act.dest !== exp.dest) report_mismatch("branch_data.dest", exp.dest, act.dest);
    endtask

    // Lane result as the ISA defines it, zero for branches other than jal
    function automatic logic [31:0] ref_lane(exec_req_t r, logic [31:0] a, logic [31:0] b);
        int          sa;
        int          sb;
        longint      sp;
        logic [63:0] up;
        sa = a;
        sb = b;
        sp = longint'(sa) * longint'(sb);
        up = 64'(a) * 64'(b);
        if (r.op_class == OP_CLASS_MULDIV) begin
            case (r.op.mdv.op)
                MDV_MUL:   return up[31:0];
                MDV_MULH:  return sp[63:32];
                MDV_MULHU: return up[63:32];
                MDV_DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
                MDV_REMU:  return (b == 0) ? a : a % b;
                MDV_DIV, MDV_REM: begin
                    if (b == 0) return (r.op.mdv.op == MDV_DIV) ? 32'hffff_ffff : a;
                    if (a == 32'h8000_0000 && sb == -1) return (r.op.mdv.op == MDV_DIV) ? a : 0;
                    return (r.op.mdv.op == MDV_DIV) ? sa / sb : sa % sb;
                end
                default:   return 32'd0;
            endcase
        end
        case (r.op.int_op)
            INT_ADD:  return a + b;
            INT_SUB:  return a - b;
            INT_AND:  return a & b;
            INT_OR:   return a | b;
            INT_XOR:  return a ^ b;
            INT_SLL:  return a << b[4:0];
            INT_SRL:  return a >> b[4:0];
            INT_SRA:  return sa >>> b[4:0];
            INT_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
            INT_SLTU: return (a < b) ? 32'd1 : 32'd0;
            INT_JAL:  return r.pc + 32'd4;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic commit_t ref_commit(exec_req_t r);
        commit_t c;
        c.uuid  = r.uuid;
        c.wid   = r.wid;
        c.tmask = r.tmask;
        c.pc    = r.pc;
        c.rd    = r.rd;
        c.wb    = r.wb;
        for (int i = 0; i < NL; i++) begin
            c.data[i] = r.tmask[i] ? ref_lane(r, r.rs1_data[i], r.rs2_data[i]) : 32'd0;
        end
        return c;
    endfunction

    // The branch compare is taken from the lowest active lane
    function automatic branch_t ref_branch(exec_req_t r);
        branch_t     br;
        int          lane;
        logic [31:0] a;
        logic [31:0] b;
        lane = 0;
        while (lane < NL - 1 && !r.tmask[lane]) begin
            lane++;
        end
        a = r.rs1_data[lane];
        b = r.rs2_data[lane];
        case (r.op.int_op)
            INT_BEQ:  br.taken = (a == b);
            INT_BNE:  br.taken = (a != b);
            INT_BLT:  br.taken = ($signed(a) < $signed(b));
            INT_BGE:  br.taken = !($signed(a) < $signed(b));
            INT_BLTU: br.taken = (a < b);
            default:  br.taken = 1'b1;
        endcase
        br.wid  = r.wid;
        br.dest = br.taken ? r.pc + r.imm : r.pc + 32'd4;
        return br;
    endfunction

    function automatic exec_req_t make_req(op_class_e c, logic [3:0] op);
        exec_req_t   r;
        logic [31:0] x;
        x = xorshift();
        r.uuid  = next_uuid;
        next_uuid++;
        r.wid   = x[1:0];
        r.tmask = (x[5:2] == 4'd0) ? 4'b0100 : x[5:2];
        r.rd    = x[10:6];
        r.imm   = {{19{x[31]}}, x[31:20], 1'b0};
        r.pc    = xorshift() & 32'h0000_fffc;
        r.op_class = c;
        if (c == OP_CLASS_MULDIV) begin
            r.op.mdv.pad = 1'b0;
            r.op.mdv.op  = mdv_op_e'(op[2:0]);
        end else begin
            r.op.int_op = int_op_e'(op);
        end
        r.wb = !(c == OP_CLASS_BRANCH && op != INT_JAL);
        for (int i = 0; i < NL; i++) begin
            r.rs1_data[i] = xorshift();
            r.rs2_data[i] = xorshift();
        end
        return r;
    endfunction

    // Called at 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic issue(input exec_req_t req, output time t_acc);
        exp_q.push_back(ref_commit(req));
        if (req.op_class == OP_CLASS_BRANCH) br_q.push_back(ref_branch(req));
        disp_valid = 1'b1;
        disp_req   = req;
        @(negedge clk);
        while (!disp_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        t_acc = $time;
        #1;
    endtask

    task automatic drain();
        disp_valid = 1'b0;
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0 || br_q.size() != 0);
        #1;
    endtask

    task automatic test_reset_state();
        check_flag("commit_valid", 1'b0, commit_valid);
        check_flag("branch_valid", 1'b0, branch_valid);
        check_flag("disp_ready", 1'b1, disp_ready);
    endtask

    task automatic test_arith();
        time t;
        for (int k = 0; k < N_ARITH; k++) begin
            issue(make_req(OP_CLASS_ARITH, 4'(k % 10)), t);
        end
        drain();
    endtask

    task automatic test_branch();
        exec_req_t req;
        time       t;
        for (int k = 0; k < N_BRANCH; k++) begin
            req = make_req(OP_CLASS_BRANCH, 4'(10 + k % 6));
            // Every other round uses equal operands so both outcomes occur
            if ((k / 6) % 2 == 0) req.rs2_data = req.rs1_data;
            issue(req, t);
        end
        drain();
    endtask

    task automatic test_muldiv();
        exec_req_t req;
        time       t;
        for (int k = 0; k < N_MULDIV; k++) begin
            req = make_req(OP_CLASS_MULDIV, 4'(k % 7));
            if (k >= 14) begin
                // Lane 0 overflows, lane 1 divides by zero
                req.tmask    = 4'hf;
                req.rs1_data = {32'hffff_ffff, 32'hffff_fff9, 32'd5, 32'h8000_0000};
                req.rs2_data = {32'hffff_ffff, 32'd2, 32'd0, 32'hffff_ffff};
            end
            issue(req, t);
        end
        drain();
    endtask

    task automatic test_mixed();
        exec_req_t   reqs[N_MIXED];
        logic [31:0] x;
        time         t;
        for (int k = 0; k < N_MIXED; k++) begin
            x = xorshift();
            case (x % 3)
                0:       reqs[k] = make_req(OP_CLASS_ARITH, 4'(x[7:4] % 10));
                1:       reqs[k] = make_req(OP_CLASS_BRANCH, 4'(10 + x[7:4] % 6));
                default: reqs[k] = make_req(OP_CLASS_MULDIV, 4'(x[7:4] % 7));
            endcase
        end
        @(negedge clk);
        rand_ready = 1'b1;
        @(posedge clk);
        #1;
        for (int k = 0; k < N_MIXED; k++) begin
            issue(reqs[k], t);
        end
        drain();
        @(negedge clk);
        rand_ready = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic measure_latency(op_class_e c, int exp_cycles);
        time t_acc;
        int  lat;
        issue(make_req(c, 4'd0), t_acc);
        disp_valid = 1'b0;
        @(negedge clk);
        while (!commit_valid) begin
            @(negedge clk);
        end
        lat = int'(($time - t_acc - 5) / 10) + 1;
        if (lat != exp_cycles) report_mismatch("commit latency in cycles", exp_cycles, lat);
        drain();
    endtask

    task automatic test_latency();
        time t_prev;
        time t_acc;
        measure_latency(OP_CLASS_ARITH, 3);
        measure_latency(OP_CLASS_MULDIV, 5);
        for (int k = 0; k < N_LATENCY - 2; k++) begin
            issue(make_req(OP_CLASS_MULDIV, 4'(k)), t_acc);
            if (k > 0 && t_acc - t_prev != 10) begin
                report_mismatch("muldiv accept spacing in ns", 10, 32'(t_acc - t_prev));
            end
            t_prev = t_acc;
        end
        drain();
    endtask

    task automatic match_commit(commit_t act);
        int idx;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].uuid == act.uuid) idx = i;
        end
        if (idx < 0) begin
            report_problem($sformatf("commit for uuid %0d that is not outstanding", act.uuid));
        end else begin
            check_commit(exp_q[idx], act);
            exp_q.delete(idx);
        end
    endtask

    // Inputs change only 1 ns after a rising edge, so the falling edge sees final values
    always @(negedge clk) begin
        if (alu_unit_inst.sva_inst.fail_count != 0) begin
            report_problem("a bound assertion failed");
        end
        if (rst_n && commit_valid && commit_ready) match_commit(commit_data);
        if (rst_n && branch_valid) begin
            if (br_q.size() == 0) begin
                report_problem("branch strobe with no branch outstanding");
            end else begin
                check_branch(br_q.pop_front(), branch_data);
            end
        end
    end

    always @(posedge clk) begin
        logic [31:0] x;
        #1;
        if (rand_ready) begin
            x = xorshift();
            commit_ready = x[7];
        end else begin
            commit_ready = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_problem("watchdog expired before the tests finished");
    end

    initial begin
        rst_n        = 1'b1;
        disp_valid   = 1'b0;
        disp_req     = '0;
        commit_ready = 1'b1;
        #1;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        test_arith();
        test_branch();
        test_muldiv();
        test_mixed();
        test_latency();
        // Late duplicates would show up as commits that are not outstanding
        repeat (10) @(posedge clk);
        if (alu_unit_inst.sva_inst.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_problem("bound assertion failures were reported");
        end
    end

endmodule

// ==== dv/alu_unit_sva.sv ====
// Execute cluster checks
// Commit stall stability, branch strobe rules and quiet outputs in reset
`timescale 1ns/10ps

module alu_unit_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    commit_valid,
    input logic                    commit_ready,
    input alu_commit_pkg::commit_t commit_data,
    input logic                    branch_valid,
    input logic                    int_rsp_valid,
    input logic                    int_rsp_ready
);
    int fail_count = 0;

    // A stalled commit keeps both its valid and its record
    commit_stable: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_data))
    else begin
        $error("commit_data changed while the commit port was stalled");
        fail_count++;
    end

    // A strobe marks a branch result entering the integer output register, so a
    // second strobe in a row needs the previous result to have been handed off
    branch_once: assert property (@(posedge clk) disable iff (!rst_n)
        branch_valid |-> int_rsp_valid && (!$past(branch_valid) || $past(int_rsp_ready)))
    else begin
        $error("branch_valid repeated for a branch still held in the integer unit");
        fail_count++;
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !commit_valid && !branch_valid)
    else begin
        $error("valid output high during reset");
        fail_count++;
    end

endmodule

// ==== design/alu_unit.sv ====
// Integer execute cluster top
// Dispatch stage, integer unit, multiply/divide unit and the commit arbiter
`timescale 1ns/10ps

module alu_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    disp_valid,
    input  alu_op_pkg::exec_req_t   disp_req,
    output logic                    disp_ready,
    output logic                    commit_valid,
    output alu_commit_pkg::commit_t commit_data,
    input  logic                    commit_ready,
    output logic                    branch_valid,
    output alu_commit_pkg::branch_t branch_data
);
    import alu_op_pkg::*;
    import alu_commit_pkg::*;

    // Both units see the same request, only the valid lines differ
    exec_req_t exec_req;
    logic      int_valid;
    logic      int_ready;
    logic      mdv_valid;
    logic      mdv_ready;

    commit_t   int_rsp;
    logic      int_rsp_valid;
    logic      int_rsp_ready;
    commit_t   mdv_rsp;
    logic      mdv_rsp_valid;
    logic      mdv_rsp_ready;

    alu_dispatch dispatch_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (disp_valid),
        .in_req    (disp_req),
        .in_ready  (disp_ready),
        .int_valid (int_valid),
        .mdv_valid (mdv_valid),
        .out_req   (exec_req),
        .int_ready (int_ready),
        .mdv_ready (mdv_ready)
    );

    alu_int_unit int_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (int_valid),
        .in_req       (exec_req),
        .in_ready     (int_ready),
        .out_valid    (int_rsp_valid),
        .out_rsp      (int_rsp),
        .out_ready    (int_rsp_ready),
        .branch_valid (branch_valid),
        .branch_data  (branch_data)
    );

    alu_muldiv_unit mdv_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mdv_valid),
        .in_req    (exec_req),
        .in_ready  (mdv_ready),
        .out_valid (mdv_rsp_valid),
        .out_rsp   (mdv_rsp),
        .out_ready (mdv_rsp_ready)
    );

    alu_rsp_arb rsp_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .int_valid (int_rsp_valid),
        .int_rsp   (int_rsp),
        .int_ready (int_rsp_ready),
        .mdv_valid (mdv_rsp_valid),
        .mdv_rsp   (mdv_rsp),
        .mdv_ready (mdv_rsp_ready),
        .out_valid (commit_valid),
        .out_rsp   (commit_data),
        .out_ready (commit_ready)
    );

endmodule

// ==== design/alu_rsp_arb.sv ====
// Response arbiter
// Round-robin merge of the integer and multiply/divide result streams
// into one registered commit port
`timescale 1ns/10ps

module alu_rsp_arb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    int_valid,
    input  alu_commit_pkg::commit_t int_rsp,
    output logic                    int_ready,
    input  logic                    mdv_valid,
    input  alu_commit_pkg::commit_t mdv_rsp,
    output logic                    mdv_ready,
    output logic                    out_valid,
    output alu_commit_pkg::commit_t out_rsp,
    input  logic                    out_ready
);
    logic load;
    logic prio_mdv;
    logic grant_int;
    logic grant_mdv;

    assign load = ~out_valid | out_ready;

    // The priority input only matters when both sides request
    assign grant_int = int_valid & (~mdv_valid | ~prio_mdv);
    assign grant_mdv = mdv_valid & (~int_valid | prio_mdv);

    assign int_ready = load & grant_int;
    assign mdv_ready = load & grant_mdv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            prio_mdv  <= 1'b0;
        end else if (load) begin
            out_valid <= int_valid | mdv_valid;
            if (grant_int) begin
                prio_mdv <= 1'b1;
            end else if (grant_mdv) begin
                prio_mdv <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && (int_valid || mdv_valid)) begin
            out_rsp <= grant_mdv ? mdv_rsp : int_rsp;
        end
    end

endmodule

// ==== design/alu_muldiv_unit.sv ====
// Multiply/divide unit
// Three-stage per-lane pipeline for the RISC-V M ops, results formed in the
// first stage and carried with their tags, stalling as a whole
`timescale 1ns/10ps
`include "alu_defines.svh"

module alu_muldiv_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  alu_op_pkg::exec_req_t   in_req,
    output logic                    in_ready,
    output logic                    out_valid,
    output alu_commit_pkg::commit_t out_rsp,
    input  logic                    out_ready
);
    import alu_op_pkg::*;
    import alu_commit_pkg::*;

    localparam int XLEN = `ALU_XLEN;

    logic    advance;
    logic    s1_valid;
    logic    s2_valid;
    commit_t rsp_next;
    commit_t s1_rsp;
    commit_t s2_rsp;

    function automatic logic [XLEN-1:0] mdv_lane_op(mdv_op_e op, logic [XLEN-1:0] a,
                                                    logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod_ss;
        logic [2*XLEN-1:0] prod_uu;
        logic              div_zero;
        logic              div_ovf;
        logic [XLEN-1:0]   quo_s;
        logic [XLEN-1:0]   rem_s;
        logic [XLEN-1:0]   quo_u;
        logic [XLEN-1:0]   rem_u;
        prod_ss  = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
        prod_uu  = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        div_zero = (b == '0);
        div_ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        // RISC-V defines both corner cases instead of trapping
        if (div_zero) begin
            quo_s = '1;
            rem_s = a;
            quo_u = '1;
            rem_u = a;
        end else begin
            if (div_ovf) begin
                quo_s = a;
                rem_s = '0;
            end else begin
                quo_s = $signed(a) / $signed(b);
                rem_s = $signed(a) % $signed(b);
            end
            quo_u = a / b;
            rem_u = a % b;
        end
        case (op)
            MDV_MUL:   return prod_uu[XLEN-1:0];
            MDV_MULH:  return prod_ss[2*XLEN-1:XLEN];
            MDV_MULHU: return prod_uu[2*XLEN-1:XLEN];
            MDV_DIV:   return quo_s;
            MDV_DIVU:  return quo_u;
            MDV_REM:   return rem_s;
            MDV_REMU:  return rem_u;
            default:   return '0;
        endcase
    endfunction

    // All three stages move together when the last one can hand off
    assign advance  = ~out_valid | out_ready;
    assign in_ready = advance;

    always_comb begin
        rsp_next.uuid  = in_req.uuid;
        rsp_next.wid   = in_req.wid;
        rsp_next.tmask = in_req.tmask;
        rsp_next.pc    = in_req.pc;
        rsp_next.rd    = in_req.rd;
        rsp_next.wb    = in_req.wb;
        for (int i = 0; i < `ALU_NUM_LANES; i++) begin
            if (in_req.tmask[i]) begin
                rsp_next.data[i] = mdv_lane_op(in_req.op.mdv.op, in_req.rs1_data[i],
                                               in_req.rs2_data[i]);
            end else begin
                rsp_next.data[i] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            s1_rsp <= rsp_next;
        end
        if (advance && s1_valid) begin
            s2_rsp <= s1_rsp;
        end
        if (advance && s2_valid) begin
            out_rsp <= s2_rsp;
        end
    end

endmodule

// ==== design/alu_int_unit.sv ====
// Integer execute unit
// Per-lane arithmetic, logic, shift and compare ops plus branch resolution,
// with one output register and a single-cycle branch report
`timescale 1ns/10ps
`include "alu_defines.svh"

module alu_int_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  alu_op_pkg::exec_req_t   in_req,
    output logic                    in_ready,
    output logic                    out_valid,
    output alu_commit_pkg::commit_t out_rsp,
    input  logic                    out_ready,
    output logic                    branch_valid,
    output alu_commit_pkg::branch_t branch_data
);
    import alu_op_pkg::*;
    import alu_commit_pkg::*;

    localparam int XLEN = `ALU_XLEN;

    logic            in_fire;
    logic            is_branch;
    logic [XLEN-1:0] link_pc;
    logic [XLEN-1:0] cmp_a;
    logic [XLEN-1:0] cmp_b;
    logic            taken;
    commit_t         rsp_next;
    branch_t         br_next;

    // Branch ops other than jal leave the lane result at zero
    function automatic logic [XLEN-1:0] int_lane_op(int_op_e op, logic [XLEN-1:0] a,
                                                    logic [XLEN-1:0] b,
                                                    logic [XLEN-1:0] link);
        case (op)
            INT_ADD:  return a + b;
            INT_SUB:  return a - b;
            INT_AND:  return a & b;
            INT_OR:   return a | b;
            INT_XOR:  return a ^ b;
            INT_SLL:  return a << b[4:0];
            INT_SRL:  return a >> b[4:0];
            INT_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            INT_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            INT_SLTU: return {{(XLEN-1){1'b0}}, a < b};
            INT_JAL:  return link;
            default:  return '0;
        endcase
    endfunction

    assign in_ready  = ~out_valid | out_ready;
    assign in_fire   = in_valid & in_ready;
    assign is_branch = (in_req.op_class == OP_CLASS_BRANCH);
    assign link_pc   = in_req.pc + XLEN'(4);

    // Branch compare uses the lowest active lane
    always_comb begin
        cmp_a = in_req.rs1_data[0];
        cmp_b = in_req.rs2_data[0];
        for (int i = `ALU_NUM_LANES - 1; i >= 0; i--) begin
            if (in_req.tmask[i]) begin
                cmp_a = in_req.rs1_data[i];
                cmp_b = in_req.rs2_data[i];
            end
        end
    end

    always_comb begin
        case (in_req.op.int_op)
            INT_BEQ:  taken = (cmp_a == cmp_b);
            INT_BNE:  taken = (cmp_a != cmp_b);
            INT_BLT:  taken = ($signed(cmp_a) < $signed(cmp_b));
            INT_BGE:  taken = ($signed(cmp_a) >= $signed(cmp_b));
            INT_BLTU: taken = (cmp_a < cmp_b);
            INT_JAL:  taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        rsp_next.uuid  = in_req.uuid;
        rsp_next.wid   = in_req.wid;
        rsp_next.tmask = in_req.tmask;
        rsp_next.pc    = in_req.pc;
        rsp_next.rd    = in_req.rd;
        rsp_next.wb    = in_req.wb;
        for (int i = 0; i < `ALU_NUM_LANES; i++) begin
            if (in_req.tmask[i]) begin
                rsp_next.data[i] = int_lane_op(in_req.op.int_op, in_req.rs1_data[i],
                                               in_req.rs2_data[i], link_pc);
            end else begin
                rsp_next.data[i] = '0;
            end
        end
        br_next.wid   = in_req.wid;
        br_next.taken = taken;
        br_next.dest  = taken ? (in_req.pc + in_req.imm) : link_pc;
    end

    // The strobe rises together with out_valid for the same branch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            branch_valid <= in_fire & is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_rsp <= rsp_next;
        end
        if (in_fire && is_branch) begin
            branch_data <= br_next;
        end
    end

endmodule

// ==== design/alu_dispatch.sv ====
// Dispatch stage
// Single-entry register that accepts a warp instruction and steers it
// to the integer or the multiply/divide unit by op class
`timescale 1ns/10ps

module alu_dispatch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  alu_op_pkg::exec_req_t in_req,
    output logic                  in_ready,
    output logic                  int_valid,
    output logic                  mdv_valid,
    output alu_op_pkg::exec_req_t out_req,
    input  logic                  int_ready,
    input  logic                  mdv_ready
);
    import alu_op_pkg::*;

    logic full;
    logic is_mdv;
    logic sel_ready;

    // Class is decoded on entry so the output side only looks at one flop
    assign sel_ready = is_mdv ? mdv_ready : int_ready;
    assign in_ready  = ~full | sel_ready;
    assign int_valid = full & ~is_mdv;
    assign mdv_valid = full & is_mdv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full   <= 1'b0;
            is_mdv <= 1'b0;
        end else if (in_ready) begin
            full   <= in_valid;
            is_mdv <= in_valid && (in_req.op_class == OP_CLASS_MULDIV);
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            out_req <= in_req;
        end
    end

endmodule

// ==== design/alu_commit_pkg.sv ====
// Result types
// Commit record sent to writeback and the branch outcome report
package alu_commit_pkg;

`include "alu_defines.svh"

    typedef struct packed {
        logic [`ALU_UUID_WIDTH-1:0]                uuid;
        logic [`ALU_NW_WIDTH-1:0]                  wid;
        logic [`ALU_NUM_LANES-1:0]                 tmask;
        logic [`ALU_XLEN-1:0]                      pc;
        logic [`ALU_NR_BITS-1:0]                   rd;
        logic                                      wb;
        logic [`ALU_NUM_LANES-1:0][`ALU_XLEN-1:0] data;
    } commit_t;

    // Dest is the next program counter of the warp
    typedef struct packed {
        logic [`ALU_NW_WIDTH-1:0] wid;
        logic                     taken;
        logic [`ALU_XLEN-1:0]     dest;
    } branch_t;

endpackage

// ==== design/alu_op_pkg.sv ====
// Execute request types
// Operation classes, integer and M opcodes and the dispatched request record
package alu_op_pkg;

`include "alu_defines.svh"

    typedef enum logic [1:0] {
        OP_CLASS_ARITH  = 2'd0,
        OP_CLASS_BRANCH = 2'd1,
        OP_CLASS_MULDIV = 2'd2
    } op_class_e;

    // Integer ops, shared by the arithmetic and branch classes
    typedef enum logic [3:0] {
        INT_ADD, INT_SUB, INT_AND, INT_OR, INT_XOR, INT_SLL, INT_SRL, INT_SRA,
        INT_SLT, INT_SLTU, INT_BEQ, INT_BNE, INT_BLT, INT_BGE, INT_BLTU, INT_JAL
    } int_op_e;

    typedef enum logic [2:0] {
        MDV_MUL, MDV_MULH, MDV_MULHU, MDV_DIV, MDV_DIVU, MDV_REM, MDV_REMU
    } mdv_op_e;

    typedef struct packed {
        logic    pad;
        mdv_op_e op;
    } mdv_op_t;

    // The op word is read by the integer unit or the multiply/divide unit
    // depending on the op class
    typedef union packed {
        int_op_e int_op;
        mdv_op_t mdv;
    } alu_op_u;

    typedef struct packed {
        logic [`ALU_UUID_WIDTH-1:0]                uuid;
        logic [`ALU_NW_WIDTH-1:0]                  wid;
        logic [`ALU_NUM_LANES-1:0]                 tmask;
        logic [`ALU_XLEN-1:0]                      pc;
        op_class_e                                 op_class;
        alu_op_u                                   op;
        logic [`ALU_NR_BITS-1:0]                   rd;
        logic                                      wb;
        logic [`ALU_XLEN-1:0]                      imm;
        logic [`ALU_NUM_LANES-1:0][`ALU_XLEN-1:0] rs1_data;
        logic [`ALU_NUM_LANES-1:0][`ALU_XLEN-1:0] rs2_data;
    } exec_req_t;

endpackage

// ==== design/alu_defines.svh ====
// Execute cluster parameters
// Lane count, data width and the widths of the instruction tag fields
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Lanes per warp instruction, one per thread
`define ALU_NUM_LANES 4

// Data path width in bits
`define ALU_XLEN 32

// Warp ID bits
`define ALU_NW_WIDTH 2

// Destination register index bits
`define ALU_NR_BITS 5

// Instruction tag bits
`define ALU_UUID_WIDTH 8

`endif
